/* src/cpu_pkg.sv */
package cpu_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // data and address width
    localparam int xlen = 32;
    // register select width
    localparam int reg_addr_w = 5;
    localparam int num_regs = 32;
    // immediate field of the i view
    localparam int imm_w = 17;

    //////////////////////////////////////////////////
    // opcodes and instruction formats
    //////////////////////////////////////////////////

    // zero opcode is nop, so an all-zero word is a nop
    typedef enum logic [4:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_and  = 5'd3,
        op_or   = 5'd4,
        op_xor  = 5'd5,
        op_addi = 5'd6,
        op_lw   = 5'd7,
        op_sw   = 5'd8
    } opcode_t;

    // one instruction word, two readings
    // r view for register ops, i view for addi, lw, sw
    // sw puts its store-data register in rd
    typedef union packed {
        struct packed {
            opcode_t               opcode;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] rs1;
            logic [reg_addr_w-1:0] rs2;
            logic [11:0]           unused;
        } r;
        struct packed {
            opcode_t               opcode;
            logic [reg_addr_w-1:0] rd;
            logic [reg_addr_w-1:0] rs1;
            logic [imm_w-1:0]      imm;
        } i;
    } instr_t;

    // reset values
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] instr_bytes = 32'd4;
    localparam instr_t nop_instr = '0;

endpackage

/* src/fetch.sv */
`timescale 1ns/1ps

module fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     done,
    input  logic [cpu_pkg::xlen-1:0] rdata,
    output logic                     req,
    output logic [cpu_pkg::xlen-1:0] adr,
    output cpu_pkg::instr_t          instr
);

    logic [cpu_pkg::xlen-1:0] pc;
    // fetched word waiting for the next advance
    logic [cpu_pkg::xlen-1:0] buf_word;
    logic                     buf_full;

    // ask for the word at pc until the buffer holds it
    assign req = ~buf_full;
    assign adr = pc;

    // pc, buffer state and the fetch/decode register
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= cpu_pkg::reset_pc;
            buf_full <= 1'b0;
            instr    <= cpu_pkg::nop_instr;
        end else if (!stall) begin
            // advance, hand the word to decode and move on
            instr    <= cpu_pkg::instr_t'(buf_word);
            pc       <= pc + cpu_pkg::instr_bytes;
            buf_full <= 1'b0;
        end else if (done) begin
            buf_full <= 1'b1;
        end
    end

    // instruction word capture
    always_ff @(posedge clk) begin
        if (done) begin
            buf_word <= rdata;
        end
    end

endmodule

/* src/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  cpu_pkg::instr_t                instr,
    input  logic                           wb_en,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_sel,
    input  logic [cpu_pkg::xlen-1:0]       wb_data,
    output cpu_pkg::opcode_t               op,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data,
    output logic [cpu_pkg::xlen-1:0]       imm,
    output logic [cpu_pkg::reg_addr_w-1:0] rd
);

    cpu_pkg::opcode_t               dec_op;
    logic [cpu_pkg::reg_addr_w-1:0] rs2_sel;
    logic [cpu_pkg::xlen-1:0]       rd1;
    logic [cpu_pkg::xlen-1:0]       rd2;
    logic [cpu_pkg::xlen-1:0]       imm_ext;
    logic [cpu_pkg::xlen-1:0]       regs [cpu_pkg::num_regs];

    //////////////////////////////////////////////////
    // instruction decode
    //////////////////////////////////////////////////

    // unknown opcodes fall back to nop
    always_comb begin
        case (instr.r.opcode)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
            cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_addi,
            cpu_pkg::op_lw, cpu_pkg::op_sw: dec_op = instr.r.opcode;
            default: dec_op = cpu_pkg::op_nop;
        endcase
    end

    // sw reads its store data through rd of the i view
    assign rs2_sel = (dec_op == cpu_pkg::op_sw) ? instr.i.rd : instr.r.rs2;

    // sign extended immediate, only for i-view ops
    always_comb begin
        if (dec_op == cpu_pkg::op_addi || dec_op == cpu_pkg::op_lw ||
            dec_op == cpu_pkg::op_sw) begin
            imm_ext = {{(cpu_pkg::xlen - cpu_pkg::imm_w){instr.i.imm[cpu_pkg::imm_w-1]}},
                       instr.i.imm};
        end else begin
            imm_ext = '0;
        end
    end

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////

    // r0 reads as zero
    assign rd1 = (instr.r.rs1 == '0) ? '0 : regs[instr.r.rs1];
    assign rd2 = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    // writeback lands at the advance, r0 writes dropped
    always_ff @(posedge clk) begin
        if (!stall && wb_en && wb_sel != '0) begin
            regs[wb_sel] <= wb_data;
        end
    end

    // decode/execute register, control part
    always_ff @(posedge clk) begin
        if (reset) begin
            op <= cpu_pkg::op_nop;
            rd <= '0;
        end else if (!stall) begin
            op <= dec_op;
            rd <= instr.r.rd;
        end
    end

    // decode/execute register, operands
    always_ff @(posedge clk) begin
        if (!stall) begin
            rs1_data <= rd1;
            rs2_data <= rd2;
            imm      <= imm_ext;
        end
    end

endmodule

/* src/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  cpu_pkg::opcode_t               op,
    input  logic [cpu_pkg::xlen-1:0]       rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       rs2_data,
    input  logic [cpu_pkg::xlen-1:0]       imm,
    input  logic [cpu_pkg::reg_addr_w-1:0] rd,
    output cpu_pkg::opcode_t               mem_op,
    output logic [cpu_pkg::xlen-1:0]       result,
    output logic [cpu_pkg::xlen-1:0]       store_data,
    output logic [cpu_pkg::reg_addr_w-1:0] rd_out
);

    logic                     use_imm;
    logic [cpu_pkg::xlen-1:0] opnd_b;
    logic [cpu_pkg::xlen-1:0] alu_out;

    // second operand select
    assign use_imm = (op == cpu_pkg::op_addi) || (op == cpu_pkg::op_lw) ||
                     (op == cpu_pkg::op_sw);
    assign opnd_b  = use_imm ? imm : rs2_data;

    // alu, addi/lw/sw all add, address for the memory ops
    always_comb begin
        case (op)
            cpu_pkg::op_add, cpu_pkg::op_addi,
            cpu_pkg::op_lw, cpu_pkg::op_sw: alu_out = rs1_data + opnd_b;
            cpu_pkg::op_sub: alu_out = rs1_data - opnd_b;
            cpu_pkg::op_and: alu_out = rs1_data & opnd_b;
            cpu_pkg::op_or:  alu_out = rs1_data | opnd_b;
            cpu_pkg::op_xor: alu_out = rs1_data ^ opnd_b;
            default:         alu_out = '0;
        endcase
    end

    // execute/memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_op <= cpu_pkg::op_nop;
        end else if (!stall) begin
            mem_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result     <= alu_out;
            store_data <= rs2_data;
            rd_out     <= rd;
        end
    end

endmodule

/* src/memory.sv */
`timescale 1ns/1ps

module memory (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  logic                           done,
    input  logic [cpu_pkg::xlen-1:0]       rdata,
    input  cpu_pkg::opcode_t               mem_op,
    input  logic [cpu_pkg::xlen-1:0]       result,
    input  logic [cpu_pkg::xlen-1:0]       store_data,
    input  logic [cpu_pkg::reg_addr_w-1:0] rd_out,
    output logic                           req,
    output logic                           we,
    output logic [cpu_pkg::xlen-1:0]       adr,
    output logic [cpu_pkg::xlen-1:0]       wdata,
    output logic                           wb_en,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_sel,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);

    logic                     is_load;
    logic                     got;
    logic                     writes_reg;
    logic [cpu_pkg::xlen-1:0] load_data;

    assign is_load = (mem_op == cpu_pkg::op_lw);
    assign we      = (mem_op == cpu_pkg::op_sw);

    // data request held until this step's access is done
    assign req   = (is_load | we) & ~got;
    assign adr   = result;
    assign wdata = store_data;

    // everything but nop and sw writes a register
    assign writes_reg = (mem_op != cpu_pkg::op_nop) && !we;

    // access-done flag and the writeback register control
    always_ff @(posedge clk) begin
        if (reset) begin
            got    <= 1'b0;
            wb_en  <= 1'b0;
            wb_sel <= '0;
        end else if (!stall) begin
            got    <= 1'b0;
            wb_en  <= writes_reg;
            wb_sel <= rd_out;
        end else if (done) begin
            got <= 1'b1;
        end
    end

    // load capture and writeback data select
    always_ff @(posedge clk) begin
        if (done) begin
            load_data <= rdata;
        end
        if (!stall) begin
            wb_data <= is_load ? load_data : result;
        end
    end

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     f_req,
    input  logic [cpu_pkg::xlen-1:0] f_adr,
    input  logic                     m_req,
    input  logic                     m_we,
    input  logic [cpu_pkg::xlen-1:0] m_adr,
    input  logic [cpu_pkg::xlen-1:0] m_wdata,
    output logic                     f_done,
    output logic                     m_done,
    output logic [cpu_pkg::xlen-1:0] rdata,
    output logic                     stall,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [cpu_pkg::xlen-1:0] wb_adr,
    output logic [cpu_pkg::xlen-1:0] wb_dat_w,
    input  logic [cpu_pkg::xlen-1:0] wb_dat_r,
    input  logic                     wb_ack
);

    // cycle in progress and who owns it
    logic busy;
    logic owner_mem;
    // per-port completed in this step
    logic f_cmp;
    logic m_cmp;
    logic f_pend;
    logic m_pend;

    assign f_pend = f_req & ~f_cmp;
    assign m_pend = m_req & ~m_cmp;

    // nothing pending means advance
    assign stall = f_pend | m_pend;

    //////////////////////////////////////////////////
    // bus drive for the owner
    //////////////////////////////////////////////////

    assign wb_cyc   = busy;
    assign wb_stb   = busy;
    // fetch only reads
    assign wb_we    = owner_mem & m_we;
    assign wb_adr   = owner_mem ? m_adr : f_adr;
    assign wb_dat_w = m_wdata;

    // ack routed to the owner
    assign f_done = busy & ~owner_mem & wb_ack;
    assign m_done = busy & owner_mem & wb_ack;
    assign rdata  = wb_dat_r;

    // grant, memory stage first, then hold until ack
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            owner_mem <= 1'b0;
            f_cmp     <= 1'b0;
            m_cmp     <= 1'b0;
        end else if (busy) begin
            if (wb_ack) begin
                busy <= 1'b0;
                if (owner_mem) begin
                    m_cmp <= 1'b1;
                end else begin
                    f_cmp <= 1'b1;
                end
            end
        end else if (!stall) begin
            // advance closes the step
            f_cmp <= 1'b0;
            m_cmp <= 1'b0;
        end else if (m_pend) begin
            busy      <= 1'b1;
            owner_mem <= 1'b1;
        end else begin
            busy      <= 1'b1;
            owner_mem <= 1'b0;
        end
    end

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [cpu_pkg::xlen-1:0] wb_adr,
    output logic [cpu_pkg::xlen-1:0] wb_dat_w,
    input  logic [cpu_pkg::xlen-1:0] wb_dat_r,
    input  logic                     wb_ack
);

    //////////////////////////////////////////////////
    // arbiter side
    //////////////////////////////////////////////////

    // global hold, low for one cycle per advance
    logic stall;
    // shared read data back from the bus
    logic [cpu_pkg::xlen-1:0] bus_rdata;

    // fetch request group
    logic                     f_req;
    logic [cpu_pkg::xlen-1:0] f_adr;
    logic                     f_done;

    // memory stage request group
    logic                     m_req;
    logic                     m_we;
    logic [cpu_pkg::xlen-1:0] m_adr;
    logic [cpu_pkg::xlen-1:0] m_wdata;
    logic                     m_done;

    //////////////////////////////////////////////////
    // pipeline registers between stages
    //////////////////////////////////////////////////

    // fetch/decode
    cpu_pkg::instr_t fd_instr;

    // decode/execute
    cpu_pkg::opcode_t               de_op;
    logic [cpu_pkg::xlen-1:0]       de_rs1_data;
    logic [cpu_pkg::xlen-1:0]       de_rs2_data;
    logic [cpu_pkg::xlen-1:0]       de_imm;
    logic [cpu_pkg::reg_addr_w-1:0] de_rd;

    // execute/memory
    cpu_pkg::opcode_t               ex_mem_op;
    logic [cpu_pkg::xlen-1:0]       ex_result;
    logic [cpu_pkg::xlen-1:0]       ex_store_data;
    logic [cpu_pkg::reg_addr_w-1:0] ex_rd;

    // writeback register, back into the register file
    logic                           wb_en;
    logic [cpu_pkg::reg_addr_w-1:0] wb_sel;
    logic [cpu_pkg::xlen-1:0]       wb_data;

    fetch u_fetch (
        .clk(clk), .reset(reset), .stall(stall),
        .done(f_done), .rdata(bus_rdata),
        .req(f_req), .adr(f_adr), .instr(fd_instr)
    );

    decode u_decode (
        .clk(clk), .reset(reset), .stall(stall), .instr(fd_instr),
        .wb_en(wb_en), .wb_sel(wb_sel), .wb_data(wb_data),
        .op(de_op), .rs1_data(de_rs1_data), .rs2_data(de_rs2_data),
        .imm(de_imm), .rd(de_rd)
    );

    execute u_execute (
        .clk(clk), .reset(reset), .stall(stall), .op(de_op),
        .rs1_data(de_rs1_data), .rs2_data(de_rs2_data), .imm(de_imm), .rd(de_rd),
        .mem_op(ex_mem_op), .result(ex_result), .store_data(ex_store_data),
        .rd_out(ex_rd)
    );

    memory u_memory (
        .clk(clk), .reset(reset), .stall(stall),
        .done(m_done), .rdata(bus_rdata),
        .mem_op(ex_mem_op), .result(ex_result), .store_data(ex_store_data),
        .rd_out(ex_rd),
        .req(m_req), .we(m_we), .adr(m_adr), .wdata(m_wdata),
        .wb_en(wb_en), .wb_sel(wb_sel), .wb_data(wb_data)
    );

    bus_arbiter u_bus_arbiter (
        .clk(clk), .reset(reset),
        .f_req(f_req), .f_adr(f_adr),
        .m_req(m_req), .m_we(m_we), .m_adr(m_adr), .m_wdata(m_wdata),
        .f_done(f_done), .m_done(m_done), .rdata(bus_rdata), .stall(stall),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 5 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* tb/cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_we,
    input logic [cpu_pkg::xlen-1:0] wb_adr,
    input logic [cpu_pkg::xlen-1:0] wb_dat_w,
    input logic                     wb_ack
);

    //////////////////////////////////////////////////
    // wishbone classic master rules
    //////////////////////////////////////////////////

    // strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");

    // request held steady until the slave acks
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=>
        (wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else $error("wb request changed or dropped before ack");

    // one ack ends the access
    a_stb_drop: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && wb_ack) |=> !wb_stb)
        else $error("wb_stb still high in the cycle after ack");

endmodule

bind cpu cpu_asserts u_cpu_asserts (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack)
);

/* tb/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    // program below, data at and above
    localparam logic [31:0] data_base = 32'h0000_0100;
    localparam int timeout_cycles = 3000;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // 256 words of bus memory
    logic [31:0] mem [0:255];
    // register contents the program should produce
    logic [31:0] model_regs [0:31];
    // stores in program order
    logic [31:0] exp_adr_q [$];
    logic [31:0] exp_dat_q [$];

    int          n_checks;
    int          n_errors;
    int          prog_len;
    // slave state
    logic        rst_edge;
    logic        in_txn;
    int          delay_left;
    logic        first_req;
    logic [31:0] last_fetch;

    tb_clock u_clock (.clk(clk), .reset(reset));

    cpu u_dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    //////////////////////////////////////////////////
    // program building and the register model
    //////////////////////////////////////////////////

    // background for untouched data words
    function automatic logic [31:0] fill_word(input logic [31:0] adr);
        return adr ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [16:0] imm);
        return {{15{imm[16]}}, imm};
    endfunction

    // opcode, rd, rs1, then rs2 field or 17-bit immediate
    function automatic logic [31:0] encode(input cpu_pkg::opcode_t op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [16:0] low);
        return {op, rd, rs1, low};
    endfunction

    task automatic put_word(input logic [31:0] word);
        mem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic alu_reg_op(input cpu_pkg::opcode_t op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (op)
            cpu_pkg::op_sub: r = a - b;
            cpu_pkg::op_and: r = a & b;
            cpu_pkg::op_or:  r = a | b;
            cpu_pkg::op_xor: r = a ^ b;
            default:         r = a + b;
        endcase
        // r0 stays zero
        if (rd != 5'd0) begin
            model_regs[rd] = r;
        end
        put_word(encode(op, rd, rs1, {rs2, 12'h000}));
    endtask

    task automatic add_imm(input logic [4:0] rd, input logic [4:0] rs1, input logic [16:0] imm);
        if (rd != 5'd0) begin
            model_regs[rd] = model_regs[rs1] + sign_extend(imm);
        end
        put_word(encode(cpu_pkg::op_addi, rd, rs1, imm));
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [16:0] imm);
        logic [31:0] adr;
        adr = model_regs[rs1] + sign_extend(imm);
        if (rd != 5'd0) begin
            model_regs[rd] = mem[adr[9:2]];
        end
        put_word(encode(cpu_pkg::op_lw, rd, rs1, imm));
    endtask

    // rs goes in the rd field of the i view
    task automatic store_word(input logic [4:0] rs, input logic [4:0] rs1, input logic [16:0] imm);
        exp_adr_q.push_back(model_regs[rs1] + sign_extend(imm));
        exp_dat_q.push_back(model_regs[rs]);
        put_word(encode(cpu_pkg::op_sw, rs, rs1, imm));
    endtask

    //////////////////////////////////////////////////
    // bus slave and its checks
    //////////////////////////////////////////////////

    // new access seen, fetch order
    task automatic check_request();
        if (first_req) begin
            first_req = 1'b0;
            n_checks++;
            assert (wb_adr == cpu_pkg::reset_pc && !wb_we) else begin
                n_errors++;
                $display("** Error: first wb_adr 0x%h wb_we 0x%h, expected 0x%h and 0x0",
                         wb_adr, wb_we, cpu_pkg::reset_pc);
            end
            last_fetch = wb_adr;
        end else if (!wb_we && wb_adr < data_base) begin
            n_checks++;
            assert (wb_adr == last_fetch + cpu_pkg::instr_bytes) else begin
                n_errors++;
                $display("** Error: fetch wb_adr 0x%h, expected 0x%h",
                         wb_adr, last_fetch + cpu_pkg::instr_bytes);
            end
            last_fetch = wb_adr;
        end
    endtask

    task automatic check_store();
        logic [31:0] exp_a;
        logic [31:0] exp_d;
        if (exp_adr_q.size() == 0) begin
            n_errors++;
            $display("store to 0x%h with data 0x%h that the program never made", wb_adr, wb_dat_w);
        end else begin
            exp_a = exp_adr_q.pop_front();
            exp_d = exp_dat_q.pop_front();
            n_checks += 2;
            assert (wb_adr == exp_a) else begin
                n_errors++;
                $display("** Error: store wb_adr 0x%h, expected 0x%h", wb_adr, exp_a);
            end
            assert (wb_dat_w == exp_d) else begin
                n_errors++;
                $display("** Error: store wb_dat_w 0x%h at 0x%h, expected 0x%h",
                         wb_dat_w, exp_a, exp_d);
            end
        end
    endtask

    // outputs read 1 ns after the edge, ack and read data driven then
    always begin
        @(posedge clk);
        rst_edge = reset;
        #1;
        wb_ack = 1'b0;
        // reset edge, covers the first cycle with reset low too
        if (rst_edge) begin
            n_checks++;
            assert (!wb_cyc && !wb_stb) else begin
                n_errors++;
                $display("** Error: wb_cyc 0x%h wb_stb 0x%h in reset, expected 0x0",
                         wb_cyc, wb_stb);
            end
        end
        if (wb_stb && !in_txn) begin
            in_txn = 1'b1;
            // 0 to 3 wait cycles
            delay_left = int'($urandom % 32'd4);
            check_request();
        end
        if (in_txn) begin
            if (delay_left == 0) begin
                in_txn = 1'b0;
                wb_ack = 1'b1;
                if (wb_we) begin
                    check_store();
                    mem[wb_adr[9:2]] = wb_dat_w;
                end else begin
                    wb_dat_r = mem[wb_adr[9:2]];
                end
            end else begin
                delay_left--;
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] adr;
        int          wait_cycles;
        void'($urandom(84));
        wb_ack     = 1'b0;
        wb_dat_r   = '0;
        n_checks   = 0;
        n_errors   = 0;
        prog_len   = 0;
        in_txn     = 1'b0;
        delay_left = 0;
        first_req  = 1'b1;
        last_fetch = '0;
        // nops below data_base, address pattern above
        for (int i = 0; i < 256; i++) begin
            adr = 32'(i) << 2;
            mem[i[7:0]] = (adr < data_base) ? cpu_pkg::nop_instr : fill_word(adr);
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r[4:0]] = '0;
        end
        mem[data_base[9:2]] = 32'hcafe_0001;

        // three instructions between any write and its first read
        add_imm(5'd1, 5'd0, 17'h01234);
        add_imm(5'd2, 5'd0, 17'h00f0f);
        // negative immediate
        add_imm(5'd3, 5'd0, 17'h1fffb);
        load_word(5'd4, 5'd0, 17'h00100);
        // lost write to r0
        add_imm(5'd0, 5'd0, 17'h00077);
        alu_reg_op(cpu_pkg::op_add, 5'd5, 5'd1, 5'd2);
        alu_reg_op(cpu_pkg::op_sub, 5'd6, 5'd1, 5'd3);
        alu_reg_op(cpu_pkg::op_and, 5'd7, 5'd1, 5'd2);
        alu_reg_op(cpu_pkg::op_or, 5'd8, 5'd1, 5'd3);
        alu_reg_op(cpu_pkg::op_xor, 5'd9, 5'd1, 5'd3);
        // load result through writeback into an addi
        add_imm(5'd10, 5'd4, 17'h00010);
        store_word(5'd1, 5'd0, 17'h00104);
        store_word(5'd5, 5'd0, 17'h00108);
        store_word(5'd6, 5'd0, 17'h0010c);
        store_word(5'd7, 5'd0, 17'h00110);
        store_word(5'd8, 5'd0, 17'h00114);
        store_word(5'd9, 5'd0, 17'h00118);
        store_word(5'd10, 5'd0, 17'h0011c);
        store_word(5'd0, 5'd0, 17'h00120);

        wait_cycles = 0;
        while (reset && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (reset) begin
            n_errors++;
            $display("reset was never released");
        end

        // every store has to reach the bus
        wait_cycles = 0;
        while (exp_adr_q.size() != 0 && wait_cycles < timeout_cycles) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_adr_q.size() != 0) begin
            n_errors++;
            $display("timeout with %0d stores still missing from the bus", exp_adr_q.size());
        end

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
src/cpu_pkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/bus_arbiter.sv
src/cpu.sv
tb/tb_clock.sv
tb/cpu_asserts.sv
tb/tb_cpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cpu -f src.f
./obj_dir/Vtb_cpu > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
